// File: verilog/apb_sys_pkg.sv
// APB subsystem package
// Bus widths, slot map, per-slot wait states and the ready-timeout limit
package apb_sys_pkg;

    // Bus widths
    localparam int unsigned APB_ADDR_W = 16;
    localparam int unsigned APB_DATA_W = 32;

    // Peripheral slots and registers per bank
    localparam int unsigned NB_SLOT    = 4;
    localparam int unsigned REG_NUM    = 8;
    // Word index width inside a bank
    localparam int unsigned REG_IDX_W  = $clog2(REG_NUM);

    typedef logic [APB_ADDR_W-1:0] apb_addr_t;
    typedef logic [APB_DATA_W-1:0] apb_data_t;
    typedef logic [NB_SLOT-1:0]    slot_vec_t;

    // Address map, slot i starts at 0x1000 + i*0x100
    localparam apb_addr_t SLOT_BASE [NB_SLOT] = '{
        16'h1000,
        16'h1100,
        16'h1200,
        16'h1300
    };
    // Decoded span per slot, eight words
    localparam apb_addr_t SLOT_SIZE = 16'h0020;

    // Wait states per slot, slot 3 is slow enough to hit the timeout
    localparam int unsigned SLOT_WAIT [NB_SLOT] = '{0, 2, 5, 40};
    // Wait counter width, holds up to 63 wait states
    localparam int unsigned WAIT_CNT_W = 6;

    // Cycles of psel high before a forced completion
    localparam int unsigned RTO_LIMIT = 16;
    localparam int unsigned RTO_CNT_W = $clog2(RTO_LIMIT);

endpackage

// File: verilog/apb_node.sv
// APB node
// Decodes the address into a one-hot slot select and muxes the slot response back
`timescale 1ns/10ps

module apb_node import apb_sys_pkg::*; (
    // Slave port from the master
    input  logic                     psel_i,
    input  logic                     penable_i,
    input  logic                     pwrite_i,
    input  apb_addr_t                paddr_i,
    input  apb_data_t                pwdata_i,
    output apb_data_t                prdata_o,
    output logic                     pready_o,
    output logic                     pslverr_o,

    // Master ports toward the slots
    output slot_vec_t                psel_o,
    output logic                     penable_o,
    output logic                     pwrite_o,
    output apb_addr_t                paddr_o,
    output apb_data_t                pwdata_o,
    input  apb_data_t [NB_SLOT-1:0]  prdata_i,
    input  slot_vec_t                pready_i,
    input  slot_vec_t                pslverr_i
);

    slot_vec_t slot_hit;

    // Range compare against the fixed map
    always_comb begin
        for (int i = 0; i < NB_SLOT; i++) begin
            slot_hit[i] = (paddr_i >= SLOT_BASE[i]) &&
                          (paddr_i <  SLOT_BASE[i] + SLOT_SIZE);
        end
    end

    // Only the addressed slot sees psel
    assign psel_o    = psel_i ? slot_hit : '0;

    // Shared request lines, qualified by psel at each slot
    assign penable_o = penable_i;
    assign pwrite_o  = pwrite_i;
    assign paddr_o   = paddr_i;
    assign pwdata_o  = pwdata_i;

    // Response mux
    always_comb begin
        // No slot matched: error completion in the first access cycle
        prdata_o  = '0;
        pready_o  = psel_i & penable_i;
        pslverr_o = psel_i & penable_i;
        for (int i = 0; i < NB_SLOT; i++) begin
            if (slot_hit[i]) begin
                prdata_o  = prdata_i[i];
                pready_o  = pready_i[i];
                pslverr_o = pslverr_i[i];
            end
        end
    end

endmodule

// File: verilog/apb_rto_timer.sv
// APB ready-timeout timer
// Counts cycles of an open transfer and pulses rto when the limit is reached
`timescale 1ns/10ps

module apb_rto_timer import apb_sys_pkg::*; (
    input  logic clk_i,
    input  logic rst_n_i,
    // High while the master holds psel
    input  logic start_i,
    // Merged pready, transfer completes this cycle
    input  logic done_i,
    output logic rto_o
);

    logic [RTO_CNT_W-1:0] rto_cnt;
    logic                 at_limit;

    // Count value of the RTO_LIMIT-th psel cycle
    assign at_limit = (rto_cnt == RTO_CNT_W'(RTO_LIMIT - 1));

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rto_cnt <= '0;
        end else if (!start_i || done_i) begin
            // Idle or completed, restart for the next transfer
            rto_cnt <= '0;
        end else if (!at_limit) begin
            rto_cnt <= rto_cnt + 1'b1;
        end
    end

    // Single pulse, done_i follows rto and clears the count
    assign rto_o = start_i & at_limit;

endmodule

// File: verilog/apb_node_wrap.sv
// APB node wrapper
// Merges the ready timeout into pready/pslverr and reports the timed-out slot
`timescale 1ns/10ps

module apb_node_wrap import apb_sys_pkg::*; (
    // Timeout handshake with the timer
    input  logic                     rto_i,
    output logic                     start_rto_o,
    output slot_vec_t                peripheral_rto_o,

    // Slave port from the master
    input  logic                     psel_i,
    input  logic                     penable_i,
    input  logic                     pwrite_i,
    input  apb_addr_t                paddr_i,
    input  apb_data_t                pwdata_i,
    output apb_data_t                prdata_o,
    output logic                     pready_o,
    output logic                     pslverr_o,

    // Master ports toward the slots
    output slot_vec_t                psel_o,
    output logic                     penable_o,
    output logic                     pwrite_o,
    output apb_addr_t                paddr_o,
    output apb_data_t                pwdata_o,
    input  apb_data_t [NB_SLOT-1:0]  prdata_i,
    input  slot_vec_t                pready_i,
    input  slot_vec_t                pslverr_i
);

    apb_data_t node_prdata;
    logic      node_pready;
    logic      node_pslverr;

    // Timer runs while the master holds psel
    assign start_rto_o      = psel_i;

    // Forced completion on timeout, error and no data
    assign pready_o         = node_pready | rto_i;
    assign pslverr_o        = node_pslverr | rto_i;
    assign prdata_o         = rto_i ? '0 : node_prdata;

    // Slot that was selected when the timer fired
    assign peripheral_rto_o = rto_i ? psel_o : '0;

    apb_node u_apb_node (
        .psel_i    ( psel_i       ),
        .penable_i ( penable_i    ),
        .pwrite_i  ( pwrite_i     ),
        .paddr_i   ( paddr_i      ),
        .pwdata_i  ( pwdata_i     ),
        .prdata_o  ( node_prdata  ),
        .pready_o  ( node_pready  ),
        .pslverr_o ( node_pslverr ),
        .psel_o    ( psel_o       ),
        .penable_o ( penable_o    ),
        .pwrite_o  ( pwrite_o     ),
        .paddr_o   ( paddr_o      ),
        .pwdata_o  ( pwdata_o     ),
        .prdata_i  ( prdata_i     ),
        .pready_i  ( pready_i     ),
        .pslverr_i ( pslverr_i    )
    );

endmodule

// File: verilog/apb_reg_bank.sv
// APB register bank peripheral
// Seven read/write registers plus a read-only ID, with fixed wait states
`timescale 1ns/10ps

module apb_reg_bank import apb_sys_pkg::*; #(
    parameter int unsigned WAIT    = 0,
    parameter int unsigned SLOT_ID = 0
) (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      psel_i,
    input  logic      penable_i,
    input  logic      pwrite_i,
    input  apb_addr_t paddr_i,
    input  apb_data_t pwdata_i,
    output apb_data_t prdata_o,
    output logic      pready_o,
    output logic      pslverr_o
);

    apb_data_t             regs [REG_NUM-1];
    logic [WAIT_CNT_W-1:0] wait_cnt;
    logic [REG_IDX_W-1:0]  reg_idx;
    logic                  access;
    logic                  id_sel;
    logic                  wr_en;

    // Word index within the bank
    assign reg_idx = paddr_i[REG_IDX_W+1:2];
    assign id_sel  = (reg_idx == REG_IDX_W'(REG_NUM - 1));
    assign access  = psel_i & penable_i;

    // Wait states, counter cleared outside the access phase
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wait_cnt <= '0;
        end else if (!access || pready_o) begin
            wait_cnt <= '0;
        end else begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    assign pready_o  = access & (wait_cnt == WAIT_CNT_W'(WAIT));
    // Writes to the ID register are refused
    assign pslverr_o = pready_o & pwrite_i & id_sel;
    // Commit only on the completing cycle
    assign wr_en     = pready_o & pwrite_i & ~id_sel;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < REG_NUM - 1; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            for (int i = 0; i < REG_NUM - 1; i++) begin
                if (reg_idx == REG_IDX_W'(i)) regs[i] <= pwdata_i;
            end
        end
    end

    // Read mux, top word returns the slot index
    always_comb begin
        prdata_o = APB_DATA_W'(SLOT_ID);
        for (int i = 0; i < REG_NUM - 1; i++) begin
            if (reg_idx == REG_IDX_W'(i)) prdata_o = regs[i];
        end
    end

endmodule

// File: verilog/apb_subsys_top.sv
// APB peripheral subsystem top level
// Node wrapper, ready-timeout timer and four register banks
`timescale 1ns/10ps

module apb_subsys_top import apb_sys_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    // APB slave port
    input  logic      psel_i,
    input  logic      penable_i,
    input  logic      pwrite_i,
    input  apb_addr_t paddr_i,
    input  apb_data_t pwdata_i,
    output apb_data_t prdata_o,
    output logic      pready_o,
    output logic      pslverr_o,
    // Slot that timed out, valid in the completion cycle
    output slot_vec_t rto_slot_o
);

    // Timer handshake
    logic                    rto;
    logic                    start_rto;

    // Slot side of the node
    slot_vec_t               slot_psel;
    logic                    slot_penable;
    logic                    slot_pwrite;
    apb_addr_t               slot_paddr;
    apb_data_t               slot_pwdata;
    apb_data_t [NB_SLOT-1:0] slot_prdata;
    slot_vec_t               slot_pready;
    slot_vec_t               slot_pslverr;

    apb_node_wrap u_apb_node_wrap (
        .rto_i            ( rto          ),
        .start_rto_o      ( start_rto    ),
        .peripheral_rto_o ( rto_slot_o   ),
        .psel_i           ( psel_i       ),
        .penable_i        ( penable_i    ),
        .pwrite_i         ( pwrite_i     ),
        .paddr_i          ( paddr_i      ),
        .pwdata_i         ( pwdata_i     ),
        .prdata_o         ( prdata_o     ),
        .pready_o         ( pready_o     ),
        .pslverr_o        ( pslverr_o    ),
        .psel_o           ( slot_psel    ),
        .penable_o        ( slot_penable ),
        .pwrite_o         ( slot_pwrite  ),
        .paddr_o          ( slot_paddr   ),
        .pwdata_o         ( slot_pwdata  ),
        .prdata_i         ( slot_prdata  ),
        .pready_i         ( slot_pready  ),
        .pslverr_i        ( slot_pslverr )
    );

    // Done is the merged pready so the count restarts per transfer
    apb_rto_timer u_apb_rto_timer (
        .clk_i   ( clk_i     ),
        .rst_n_i ( rst_n_i   ),
        .start_i ( start_rto ),
        .done_i  ( pready_o  ),
        .rto_o   ( rto       )
    );

    for (genvar i = 0; i < NB_SLOT; i++) begin : g_bank
        apb_reg_bank #(
            .WAIT    ( SLOT_WAIT[i] ),
            .SLOT_ID ( i            )
        ) u_apb_reg_bank (
            .clk_i     ( clk_i           ),
            .rst_n_i   ( rst_n_i         ),
            .psel_i    ( slot_psel[i]    ),
            .penable_i ( slot_penable    ),
            .pwrite_i  ( slot_pwrite     ),
            .paddr_i   ( slot_paddr      ),
            .pwdata_i  ( slot_pwdata     ),
            .prdata_o  ( slot_prdata[i]  ),
            .pready_o  ( slot_pready[i]  ),
            .pslverr_o ( slot_pslverr[i] )
        );
    end

endmodule

// File: testbench/apb_checker.sv
// APB subsystem checker
// Watches the top-level port, models four register banks and counts mismatches
`timescale 1ns/10ps

module apb_checker import apb_sys_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      psel_i,
    input  logic      penable_i,
    input  logic      pwrite_i,
    input  apb_addr_t paddr_i,
    input  apb_data_t pwdata_i,
    input  apb_data_t prdata_i,
    input  logic      pready_i,
    input  logic      pslverr_i,
    input  slot_vec_t rto_slot_i,
    output int        err_cnt_o,
    output int        done_cnt_o
);

    apb_data_t model [NB_SLOT][REG_NUM];
    int        err_cnt  = 0;
    int        done_cnt = 0;
    // Access cycles of the open transfer
    int        acc_cnt  = 0;

    assign err_cnt_o  = err_cnt;
    assign done_cnt_o = done_cnt;

    // Slot i spans 0x20 bytes from 0x1000 + i*0x100
    // Returns -1 when nothing matches
    function automatic int decode_slot(input apb_addr_t addr);
        int base;
        for (int i = 0; i < 4; i++) begin
            base = 32'h1000 + i * 32'h100;
            if (int'(addr) >= base && int'(addr) < base + 32'h20) return i;
        end
        return -1;
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h, paddr %h", name, got, exp, paddr_i);
            err_cnt++;
        end
    endtask

    always @(posedge clk_i or negedge rst_n_i) begin
        int        slot;
        int        idx;
        int        exp_acc;
        logic      exp_err;
        logic      data_valid;
        apb_data_t exp_data;
        slot_vec_t exp_rto;
        if (!rst_n_i) begin
            for (int s = 0; s < NB_SLOT; s++) begin
                for (int r = 0; r < REG_NUM; r++) model[s][r] = '0;
            end
            acc_cnt = 0;
        end else if (psel_i && penable_i && pready_i) begin
            acc_cnt++;
            slot       = decode_slot(paddr_i);
            idx        = int'(paddr_i[4:2]);
            // Error completion with no data unless a fast slot answers
            exp_err    = 1'b1;
            exp_data   = '0;
            exp_rto    = '0;
            data_valid = 1'b1;
            if (slot < 0) begin
                exp_acc = 1;
            end else if (slot == 3) begin
                // Timer fires in the RTO_LIMIT-th psel cycle counting the setup cycle
                exp_acc = int'(RTO_LIMIT) - 1;
                exp_rto = 4'b1000;
            end else begin
                exp_acc    = int'(SLOT_WAIT[slot]) + 1;
                exp_err    = pwrite_i && idx == 7;
                data_valid = !pwrite_i;
                exp_data   = (idx == 7) ? apb_data_t'(slot) : model[slot][idx];
            end
            check_field("pslverr_o", 32'(pslverr_i), 32'(exp_err));
            if (data_valid) check_field("prdata_o", prdata_i, exp_data);
            check_field("rto_slot_o", 32'(rto_slot_i), 32'(exp_rto));
            if (acc_cnt != exp_acc) begin
                $display("Transfer to %h completed after %0d access cycles, expected %0d",
                         paddr_i, acc_cnt, exp_acc);
                err_cnt++;
            end
            // Only clean writes to the fast slots land in a register
            if (slot >= 0 && slot < 3 && pwrite_i && !exp_err) model[slot][idx] = pwdata_i;
            acc_cnt = 0;
            done_cnt++;
        end else begin
            acc_cnt = (psel_i && penable_i) ? acc_cnt + 1 : 0;
            // Ready only ever rises in an access cycle
            if (!(psel_i && penable_i)) begin
                check_field("pready_o", 32'(pready_i), '0);
            end
            check_field("rto_slot_o", 32'(rto_slot_i), '0);
        end
    end

endmodule

// File: testbench/tb_apb_subsys.sv
// APB subsystem testbench
// LFSR-driven APB master, reset and end-of-test report
`timescale 1ns/10ps

module tb_apb_subsys import apb_sys_pkg::*; ();

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    apb_addr_t   paddr;
    apb_data_t   pwdata;
    apb_data_t   prdata;
    logic        pready;
    logic        pslverr;
    slot_vec_t   rto_slot;

    logic [31:0] lfsr_state;
    int          hang_cnt;
    int          n_xfer;
    int          chk_err;
    int          chk_done;

    // 10 ns clock
    always #5 clk = ~clk;

    apb_subsys_top UUT (
        .clk_i      ( clk      ),
        .rst_n_i    ( rst_n    ),
        .psel_i     ( psel     ),
        .penable_i  ( penable  ),
        .pwrite_i   ( pwrite   ),
        .paddr_i    ( paddr    ),
        .pwdata_i   ( pwdata   ),
        .prdata_o   ( prdata   ),
        .pready_o   ( pready   ),
        .pslverr_o  ( pslverr  ),
        .rto_slot_o ( rto_slot )
    );

    apb_checker u_apb_checker (
        .clk_i      ( clk      ),
        .rst_n_i    ( rst_n    ),
        .psel_i     ( psel     ),
        .penable_i  ( penable  ),
        .pwrite_i   ( pwrite   ),
        .paddr_i    ( paddr    ),
        .pwdata_i   ( pwdata   ),
        .prdata_i   ( prdata   ),
        .pready_i   ( pready   ),
        .pslverr_i  ( pslverr  ),
        .rto_slot_i ( rto_slot ),
        .err_cnt_o  ( chk_err  ),
        .done_cnt_o ( chk_done )
    );

    // Right-shifting Galois LFSR, taps x^32+x^30+x^26+x^25+1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    // Word address of register r in slot s
    function automatic apb_addr_t slot_addr(input int s, input int r);
        return apb_addr_t'(32'h1000 + s * 32'h100 + r * 4);
    endfunction

    // Setup cycle, then hold the access phase until pready
    task automatic run_transfer(input apb_addr_t addr, input logic wr, input apb_data_t data);
        int   cycles;
        logic done;
        cycles = 0;
        done   = 1'b0;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        while (!done && cycles < 64) begin
            @(posedge clk);
            done = pready;
            cycles++;
        end
        if (!done) begin
            $display("Transfer to %h hung, no pready within 64 access cycles", addr);
            hang_cnt++;
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        n_xfer++;
    endtask

    initial begin
        logic [31:0] pick;
        logic [31:0] reg_sel;
        logic [31:0] wr;
        logic [31:0] data;
        logic [31:0] gap;
        apb_addr_t   addr;
        clk        = 1'b0;
        rst_n      = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        lfsr_state = 32'hb1d2_f16e;
        hang_cnt   = 0;
        n_xfer     = 0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        // Reset values and ID words of the fast slots
        for (int s = 0; s < 3; s++) begin
            for (int r = 0; r < 8; r++) begin
                if (hang_cnt == 0) run_transfer(slot_addr(s, r), 1'b0, '0);
            end
        end

        // Slot pick: 0..5 fast slots, 6 the slow slot, 7 unmapped
        for (int n = 0; n < 300 && hang_cnt == 0; n++) begin
            take_bits(3, pick);
            take_bits(3, reg_sel);
            take_bits(1, wr);
            take_bits(32, data);
            if (pick < 6) begin
                addr = slot_addr(int'(pick) % 3, int'(reg_sel));
            end else if (pick == 6) begin
                addr = slot_addr(3, int'(reg_sel));
            end else begin
                take_bits(1, gap);
                // Low hole below the map or the gap past a slot's span
                addr = gap[0] ? apb_addr_t'(32'h0800 + reg_sel * 4)
                              : slot_addr(int'(reg_sel[1:0]), int'(reg_sel)) + 16'h0020;
            end
            run_transfer(addr, wr[0], data);
        end

        $display("Errors: %0d mismatches, %0d hangs, %0d of %0d transfers completed",
                 chk_err, hang_cnt, chk_done, n_xfer);
        if (chk_err == 0 && hang_cnt == 0 && chk_done == n_xfer) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
verilog/apb_sys_pkg.sv
verilog/apb_node.sv
verilog/apb_rto_timer.sv
verilog/apb_node_wrap.sv
verilog/apb_reg_bank.sv
verilog/apb_subsys_top.sv
testbench/apb_checker.sv
testbench/tb_apb_subsys.sv

// File: Makefile
# Verilator build and run of the APB subsystem testbench

.PHONY: all run lint clean

all: run

obj_dir/Vtb_apb_subsys: compile.f verilog/*.sv testbench/*.sv
	verilator --binary --top-module tb_apb_subsys -f compile.f

# Pass only when the simulation prints its pass line
run: obj_dir/Vtb_apb_subsys
	@out=$$(./obj_dir/Vtb_apb_subsys); echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

lint:
	verilator --lint-only -Wall --timing --top-module tb_apb_subsys -f compile.f

clean:
	rm -rf obj_dir
